/* rtl/soc_settings.svh */
// Address map, sizes and dividers shared by the RTL and the testbench through `include
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// System clock in Hz, also returned by the frequency register
`define SYSTEM_CLK 25000000

// Clock cycles per UART bit and per timer increment
`define UART_DIV 8
`define TIMER_DIV 4

// RAM size in 32-bit words, mapped from byte address 0
`define BRAM_WORDS 256

`define UART_TX_ADDR 32'h1000_0000
`define UART_RX_ADDR 32'h1000_0004
`define UART_LSR_ADDR 32'h1000_0008

// CLINT base and register offsets, high words sit at +4
`define CLINT_BASE 32'h1100_0000
`define CLINT_MSIP 32'h0000
`define CLINT_MTIMECMP 32'h4000
`define CLINT_MTIME 32'hBFF8

`define CPU_FREQ_ADDR 32'h1200_0000

// I/O window, both ends inclusive
`define IO_START 32'h1000_0000
`define IO_END 32'h1200_0000

`endif

/* rtl/soc_pkg.sv */
// Bus structs and enums of the peripheral fabric, referenced by scoped names from every RTL file
package soc_pkg;

  // Request from the bus master, a nonzero wstrb marks a write
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // Response to the master, rdata only meaningful while ready is high
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // Frame phases shared by the serial transmitter and receiver
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_t;

  // Targets selected by the address decoder
  typedef enum logic [2:0] {
    TGT_NONE,
    TGT_BRAM,
    TGT_UART_TX,
    TGT_UART_RX,
    TGT_LSR,
    TGT_CLINT,
    TGT_FREQ,
    TGT_IO_OTHER
  } target_t;

endpackage

/* rtl/bram.sv */
// Single-port word RAM with byte write mask, used by the top level as the main memory
module bram #(
  parameter int WORDS = 256
) (
  input  logic                     clk,
  input  logic [$clog2(WORDS)-1:0] addr,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wmask,
  output logic [31:0]              rdata
);

  logic [31:0] mem [WORDS];

  // Byte lanes are written independently
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wmask[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // Read every cycle, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* rtl/tx_uart.sv */
// 8N1 serial transmitter driven by the bus fabric, one byte per strobe while tx_free is high
`include "soc_settings.svh"

module tx_uart (
  input  logic       clk,
  input  logic       resetn,
  input  logic       strobe,
  input  logic [7:0] data,
  output logic       tx_out,
  output logic       tx_free
);

  localparam int DIV_W = $clog2(`UART_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_DIV - 1);

  soc_pkg::uart_state_t state;
  logic [DIV_W-1:0]     div_cnt;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift;

  assign tx_free = (state == soc_pkg::UART_IDLE);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= soc_pkg::UART_IDLE;
      tx_out  <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        soc_pkg::UART_IDLE: begin
          if (strobe) begin
            shift   <= data;
            tx_out  <= 1'b0;
            div_cnt <= '0;
            state   <= soc_pkg::UART_START;
          end
        end
        soc_pkg::UART_START: begin
          if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            tx_out  <= shift[0];
            state   <= soc_pkg::UART_DATA;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        soc_pkg::UART_DATA: begin
          if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            if (bit_cnt == 3'd7) begin
              // Last data bit done, drive the stop bit
              tx_out <= 1'b1;
              state  <= soc_pkg::UART_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              shift   <= shift >> 1;
              tx_out  <= shift[1];
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          if (div_cnt == DIV_LAST) begin
            state <= soc_pkg::UART_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // The fabric must hold off new bytes while a frame is on the line
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (!resetn) strobe |-> tx_free);

endmodule

/* rtl/rx_uart.sv */
// 8N1 serial receiver read by the bus fabric, keeps one byte until the fabric reads it
`include "soc_settings.svh"

module rx_uart (
  input  logic        clk,
  input  logic        resetn,
  input  logic        rx_in,
  input  logic        data_read,
  output logic [31:0] data
);

  localparam int DIV_W = $clog2(`UART_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_DIV - 1);
  localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(`UART_DIV / 2 - 1);

  soc_pkg::uart_state_t state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic [DIV_W-1:0]     div_cnt;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift;
  logic [7:0]           held;
  logic                 full;

  // Two-stage synchronizer, idle line is high
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_in;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= soc_pkg::UART_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      full    <= 1'b0;
    end else begin
      if (data_read) begin
        full <= 1'b0;
      end
      case (state)
        soc_pkg::UART_IDLE: begin
          if (!rx_sync) begin
            div_cnt <= '0;
            state   <= soc_pkg::UART_START;
          end
        end
        soc_pkg::UART_START: begin
          // Recheck the start bit at its middle to reject glitches
          if (div_cnt == HALF_LAST) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? soc_pkg::UART_IDLE : soc_pkg::UART_DATA;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        soc_pkg::UART_DATA: begin
          if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            shift   <= {rx_sync, shift[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= soc_pkg::UART_STOP;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          // Middle of the stop bit, a new byte overwrites an unread one
          if (div_cnt == DIV_LAST) begin
            held  <= shift;
            full  <= 1'b1;
            state <= soc_pkg::UART_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  assign data = full ? {24'b0, held} : '1;

endmodule

/* rtl/clint.sv */
// Core-local interruptor with msip, mtime and mtimecmp, accessed through the bus fabric
`include "soc_settings.svh"

module clint (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::mem_req_t req,
  output logic [31:0]       rdata,
  output logic              irq_soft,
  output logic              irq_timer
);

  localparam int TICK_W = $clog2(`TIMER_DIV);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`TIMER_DIV - 1);

  localparam logic [15:0] OFF_MSIP = 16'(`CLINT_MSIP);
  localparam logic [15:0] OFF_CMP_LO = 16'(`CLINT_MTIMECMP);
  localparam logic [15:0] OFF_CMP_HI = OFF_CMP_LO + 16'd4;
  localparam logic [15:0] OFF_TIME_LO = 16'(`CLINT_MTIME);
  localparam logic [15:0] OFF_TIME_HI = OFF_TIME_LO + 16'd4;

  logic [TICK_W-1:0] tick_cnt;
  logic [63:0]       mtime;
  logic [63:0]       mtimecmp;
  logic              msip;
  logic [15:0]       off;
  logic              wr;

  // Replace only the strobed bytes of a register word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign off = req.addr[15:0];
  assign wr  = valid && (|req.wstrb);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tick_cnt <= '0;
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else begin
      tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
      if (tick_cnt == TICK_LAST) begin
        mtime <= mtime + 64'd1;
      end
      // A register write takes precedence over the timer increment
      if (wr) begin
        case (off)
          OFF_MSIP:    msip <= req.wstrb[0] ? req.wdata[0] : msip;
          OFF_CMP_LO:  mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req.wdata, req.wstrb);
          OFF_CMP_HI:  mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req.wdata, req.wstrb);
          OFF_TIME_LO: mtime[31:0] <= merge_bytes(mtime[31:0], req.wdata, req.wstrb);
          OFF_TIME_HI: mtime[63:32] <= merge_bytes(mtime[63:32], req.wdata, req.wstrb);
          default: ;
        endcase
      end
    end
  end

  // Read word captured at acceptance, returned with the fabric's ready
  always_ff @(posedge clk) begin
    if (valid) begin
      case (off)
        OFF_MSIP:    rdata <= {31'b0, msip};
        OFF_CMP_LO:  rdata <= mtimecmp[31:0];
        OFF_CMP_HI:  rdata <= mtimecmp[63:32];
        OFF_TIME_LO: rdata <= mtime[31:0];
        OFF_TIME_HI: rdata <= mtime[63:32];
        default:     rdata <= '0;
      endcase
    end
  end

  assign irq_soft  = msip;
  assign irq_timer = (mtime >= mtimecmp);

endmodule

/* rtl/soc_bus.sv */
// Bus fabric of the top level, decodes the address, strobes one target and merges its response
`include "soc_settings.svh"

module soc_bus (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic              access_fault,
  output logic              bram_valid,
  input  logic [31:0]       bram_rdata,
  output logic              tx_strobe,
  input  logic              tx_free,
  output logic              rx_read,
  input  logic [31:0]       rx_data,
  output logic              clint_valid,
  input  logic [31:0]       clint_rdata
);

  localparam logic [31:0] BRAM_BYTES = 32'(`BRAM_WORDS * 4);
  localparam logic [31:0] CLINT_BASE_ADDR = `CLINT_BASE;

  soc_pkg::target_t sel;
  logic             is_write;
  logic [7:0]       tgt_valid;
  logic [7:0]       rdy_next;
  logic [7:0]       rdy_q;
  logic             tx_seen;
  logic             lsr_thre;
  logic [7:0]       lsr_byte;
  logic [31:0]      read_word;

  assign is_write = |req.wstrb;

  // Address decode, reads of the transmit register fall into the unmatched I/O space
  always_comb begin
    if (req.addr < BRAM_BYTES) begin
      sel = soc_pkg::TGT_BRAM;
    end else if (req.addr == `UART_TX_ADDR && is_write) begin
      sel = soc_pkg::TGT_UART_TX;
    end else if (req.addr == `UART_RX_ADDR) begin
      sel = soc_pkg::TGT_UART_RX;
    end else if (req.addr == `UART_LSR_ADDR) begin
      sel = soc_pkg::TGT_LSR;
    end else if (req.addr[31:16] == CLINT_BASE_ADDR[31:16]) begin
      sel = soc_pkg::TGT_CLINT;
    end else if (req.addr == `CPU_FREQ_ADDR) begin
      sel = soc_pkg::TGT_FREQ;
    end else if (req.addr >= `IO_START && req.addr <= `IO_END) begin
      sel = soc_pkg::TGT_IO_OTHER;
    end else begin
      sel = soc_pkg::TGT_NONE;
    end
  end

  // A target is strobed only while its own ready is low
  assign tgt_valid = (valid && !rdy_q[sel]) ? (8'b1 << sel) : 8'b0;

  // Transmit waits for a free UART and is taken once per request
  assign tx_strobe = tgt_valid[soc_pkg::TGT_UART_TX] && tx_free && !tx_seen;

  always_comb begin
    rdy_next = tgt_valid;
    rdy_next[soc_pkg::TGT_UART_TX] = tx_strobe;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rdy_q    <= '0;
      tx_seen  <= 1'b0;
      lsr_thre <= 1'b1;
    end else begin
      rdy_q <= rdy_next;
      if (!(valid && sel == soc_pkg::TGT_UART_TX)) begin
        tx_seen <= 1'b0;
      end else if (tx_strobe) begin
        tx_seen <= 1'b1;
      end
      if (tx_strobe) begin
        lsr_thre <= 1'b0;
      end else if (tx_free) begin
        lsr_thre <= 1'b1;
      end
    end
  end

  assign bram_valid  = tgt_valid[soc_pkg::TGT_BRAM];
  assign clint_valid = tgt_valid[soc_pkg::TGT_CLINT];
  // Receiver empties in the cycle its byte is returned
  assign rx_read     = rdy_q[soc_pkg::TGT_UART_RX] && !is_write;

  assign access_fault = valid && (sel == soc_pkg::TGT_NONE);

  // Line status with data ready in bit 0, holding empty in bit 5 and transmitter idle in bit 6
  assign lsr_byte = {1'b0, tx_free, lsr_thre, 4'b0, ~(&rx_data)};

  always_comb begin
    read_word = '0;
    if (rdy_q[soc_pkg::TGT_BRAM]) begin
      read_word = bram_rdata;
    end else if (rdy_q[soc_pkg::TGT_UART_RX]) begin
      read_word = rx_data;
    end else if (rdy_q[soc_pkg::TGT_LSR]) begin
      read_word = {16'b0, lsr_byte, 8'b0};
    end else if (rdy_q[soc_pkg::TGT_CLINT]) begin
      read_word = clint_rdata;
    end else if (rdy_q[soc_pkg::TGT_FREQ]) begin
      read_word = 32'(`SYSTEM_CLK);
    end
  end

  // Writes answer zero, the request is still held during ready
  assign rsp = '{ready: |rdy_q, rdata: is_write ? 32'b0 : read_word};

  a_one_ready: assert property (@(posedge clk) disable iff (!resetn) $onehot0(rdy_q));
  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (!resetn) $rose(rsp.ready) |-> valid);

endmodule

/* rtl/soc.sv */
// Top level of the peripheral system, the bus master port is driven by the core or the testbench
`include "soc_settings.svh"

module soc (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic              access_fault,
  output logic              uart_tx,
  input  logic              uart_rx,
  output logic              irq_soft,
  output logic              irq_timer
);

  localparam int BRAM_AW = $clog2(`BRAM_WORDS);

  logic        bram_valid;
  logic [31:0] bram_rdata;
  logic        tx_strobe;
  logic        tx_free;
  logic        rx_read;
  logic [31:0] rx_data;
  logic        clint_valid;
  logic [31:0] clint_rdata;

  soc_bus soc_bus_i (
    .clk         (clk),
    .resetn      (resetn),
    .valid       (valid),
    .req         (req),
    .rsp         (rsp),
    .access_fault(access_fault),
    .bram_valid  (bram_valid),
    .bram_rdata  (bram_rdata),
    .tx_strobe   (tx_strobe),
    .tx_free     (tx_free),
    .rx_read     (rx_read),
    .rx_data     (rx_data),
    .clint_valid (clint_valid),
    .clint_rdata (clint_rdata)
  );

  // Write lanes only open in the accepting cycle
  bram #(
    .WORDS(`BRAM_WORDS)
  ) bram_i (
    .clk  (clk),
    .addr (req.addr[BRAM_AW+1:2]),
    .wdata(req.wdata),
    .wmask(req.wstrb & {4{bram_valid}}),
    .rdata(bram_rdata)
  );

  tx_uart tx_uart_i (
    .clk    (clk),
    .resetn (resetn),
    .strobe (tx_strobe),
    .data   (req.wdata[7:0]),
    .tx_out (uart_tx),
    .tx_free(tx_free)
  );

  rx_uart rx_uart_i (
    .clk      (clk),
    .resetn   (resetn),
    .rx_in    (uart_rx),
    .data_read(rx_read),
    .data     (rx_data)
  );

  clint clint_i (
    .clk      (clk),
    .resetn   (resetn),
    .valid    (clint_valid),
    .req      (req),
    .rdata    (clint_rdata),
    .irq_soft (irq_soft),
    .irq_timer(irq_timer)
  );

endmodule

/* testbench/soc_tb.sv */
// Testbench of the peripheral system, acts as bus master from the cases file with UART loopback
`include "soc_settings.svh"

module soc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // One operation of the cases file
  typedef struct packed {
    byte         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_val;
    logic        fault;
  } case_t;

  logic              clk = 1'b0;
  logic              resetn;
  logic              valid;
  soc_pkg::mem_req_t req;
  soc_pkg::mem_rsp_t rsp;
  logic              access_fault;
  logic              uart_tx;
  logic              irq_soft;
  logic              irq_timer;

  case_t       cases[$];
  logic [8:0]  frames[$];
  logic [31:0] fill[$];
  integer      seed = 32'hcd9d546e;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;

  // Serial output looped straight back into the receiver
  soc soc_i (
    .clk         (clk),
    .resetn      (resetn),
    .valid       (valid),
    .req         (req),
    .rsp         (rsp),
    .access_fault(access_fault),
    .uart_tx     (uart_tx),
    .uart_rx     (uart_tx),
    .irq_soft    (irq_soft),
    .irq_timer   (irq_timer)
  );

  always #20 clk = ~clk;

  // Run limit scales with the number of case lines
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the cases did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // Decodes frames on the serial line, stop bit kept in bit 8
  initial begin : serial_monitor
    logic [7:0] bits;
    forever begin
      @(negedge clk);
      if (resetn && uart_tx === 1'b0) begin
        repeat (`UART_DIV / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (`UART_DIV) @(negedge clk);
          bits[i] = uart_tx;
        end
        repeat (`UART_DIV) @(negedge clk);
        frames.push_back({uart_tx, bits});
      end
    end
  end

  task automatic check_rsp(input soc_pkg::mem_rsp_t exp, input soc_pkg::mem_rsp_t got);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0d ns: rsp expected ready=%b rdata=%h, got ready=%b rdata=%h",
               $time, exp.ready, exp.rdata, got.ready, got.rdata);
      errors++;
    end
  endtask

  task automatic check_fault(input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0d ns: access_fault expected %b, got %b", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_irq(input logic [1:0] exp, input logic [1:0] got);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0d ns: {irq_timer,irq_soft} expected %b, got %b", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_byte(input logic [7:0] exp, input logic [7:0] got);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0d ns: uart_tx byte expected %h, got %h", $time, exp, got);
      errors++;
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] w;
    logic [3:0]  s;
    logic [31:0] e;
    logic        f;
    fd = $fopen("testbench/soc_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/soc_cases.txt, no cases were run");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h", op, a, w, s, e, f);
          if (n == 6) begin
            cases.push_back('{op: op, addr: a, wdata: w, wstrb: s, exp_val: e, fault: f});
          end else begin
            $display("Unreadable line in the cases file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One request held until the ready strobe, valid dropped in the next cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic fault_exp,
                            output soc_pkg::mem_rsp_t got, output logic ok);
    int wait_cnt;
    @(posedge clk);
    #2;
    valid = 1'b1;
    req = '{addr: addr, wdata: wdata, wstrb: wstrb};
    @(negedge clk);
    check_fault(fault_exp, access_fault);
    wait_cnt = 0;
    while (!rsp.ready && wait_cnt < 200) begin
      @(negedge clk);
      wait_cnt++;
    end
    ok = rsp.ready;
    got = rsp;
    if (!ok) begin
      $display("No ready for address %h within 200 cycles", addr);
      errors++;
    end
    @(posedge clk);
    #2;
    valid = 1'b0;
  endtask

  task automatic run_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic fault_exp,
                            input logic [31:0] exp_rdata);
    soc_pkg::mem_rsp_t got;
    logic              ok;
    bus_access(addr, wdata, wstrb, fault_exp, got, ok);
    if (ok) begin
      check_rsp('{ready: 1'b1, rdata: exp_rdata}, got);
    end
  endtask

  task automatic run_case(input case_t c);
    soc_pkg::mem_rsp_t got;
    logic              ok;
    logic [8:0]        frame;
    logic [31:0]       word;
    int                wait_cnt;
    case (c.op)
      "W", "R": run_access(c.addr, c.wdata, c.wstrb, c.fault, c.exp_val);
      "F": begin
        fill.delete();
        for (int i = 0; i < int'(c.wdata); i++) begin
          word = $random(seed);
          fill.push_back(word);
          run_access(c.addr + 32'(4 * i), word, 4'hf, 1'b0, 32'h0);
        end
        for (int i = 0; i < fill.size(); i++) begin
          run_access(c.addr + 32'(4 * i), 32'h0, 4'h0, 1'b0, fill[i]);
        end
      end
      "T": begin
        wait_cnt = 0;
        while (frames.size() == 0 && wait_cnt < 400) begin
          @(negedge clk);
          wait_cnt++;
        end
        if (frames.size() == 0) begin
          $display("No serial frame came back on the loopback");
          errors++;
        end else begin
          frame = frames.pop_front();
          if (!frame[8]) begin
            $display("Serial frame ended without a stop bit");
            errors++;
          end
          check_byte(c.exp_val[7:0], frame[7:0]);
          // Receiver finishes its stop bit a little after the monitor
          repeat (2 * `UART_DIV) @(negedge clk);
        end
      end
      "I": begin
        @(negedge clk);
        check_irq(c.exp_val[1:0], {irq_timer, irq_soft});
      end
      "N": begin
        bus_access(c.addr, 32'h0, 4'h0, c.fault, got, ok);
        checks++;
        if (ok && got.rdata == 32'h0) begin
          $display("ERROR at %0d ns: rsp.rdata expected nonzero, got %h", $time, got.rdata);
          errors++;
        end
      end
      default: begin
        $display("Unknown operation %c in the cases file", c.op);
        errors++;
      end
    endcase
  endtask

  initial begin : main
    int test_num;
    int test_checks;
    int test_errors;
    resetn = 1'b0;
    valid = 1'b0;
    req = '0;
    test_num = 0;
    read_cases();
    limit = cases.size() * 400;
    repeat (5) @(posedge clk);
    #2;
    resetn = 1'b1;
    test_checks = checks;
    test_errors = errors;
    foreach (cases[i]) begin
      if (cases[i].op == "E") begin
        test_num++;
        $display("Test %0d finished: %0d checks, %0d errors", test_num,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
      end else begin
        run_case(cases[i]);
      end
    end
    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/bram.sv
rtl/tx_uart.sv
rtl/rx_uart.sv
rtl/clint.sv
rtl/soc_bus.sv
rtl/soc.sv
testbench/soc_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := soc_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/soc_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/soc_cases.txt */
# Columns: op addr wdata wstrb expect fault, all hex
# W write, R read, F random fill of wdata words, T loopback byte, I {irq_timer,irq_soft}, N nonzero read, E end of test
W 00000010 11223344 f 00000000 0
W 00000010 aabbccdd 1 00000000 0
W 00000010 55667788 6 00000000 0
W 00000010 99aabbcc 8 00000000 0
R 00000010 00000000 0 996677dd 0
W 000003fc deadbeef f 00000000 0
W 000003fc 0000cafe 3 00000000 0
R 000003fc 00000000 0 deadcafe 0
F 00000100 00000008 f 00000000 0
E 00000000 00000000 0 00000000 0
R 12000000 00000000 0 017d7840 0
R 10000010 00000000 0 00000000 0
R 10000000 00000000 0 00000000 0
R 20000000 00000000 0 00000000 1
W 00000400 12345678 f 00000000 1
R 00000400 00000000 0 00000000 1
E 00000000 00000000 0 00000000 0
R 10000008 00000000 0 00006000 0
W 10000000 000000a5 1 00000000 0
T 00000000 00000000 0 000000a5 0
R 10000008 00000000 0 00006100 0
R 10000004 00000000 0 000000a5 0
R 10000004 00000000 0 ffffffff 0
E 00000000 00000000 0 00000000 0
W 10000000 0000003c 1 00000000 0
W 10000000 000000c3 1 00000000 0
T 00000000 00000000 0 0000003c 0
R 10000004 00000000 0 0000003c 0
T 00000000 00000000 0 000000c3 0
R 10000004 00000000 0 000000c3 0
R 10000008 00000000 0 00006000 0
E 00000000 00000000 0 00000000 0
I 00000000 00000000 0 00000000 0
W 11000000 00000001 f 00000000 0
I 00000000 00000000 0 00000001 0
R 11000000 00000000 0 00000001 0
W 11004000 00000000 f 00000000 0
W 11004004 00000000 f 00000000 0
I 00000000 00000000 0 00000003 0
W 11004004 ffffffff f 00000000 0
I 00000000 00000000 0 00000001 0
W 11000000 00000000 f 00000000 0
I 00000000 00000000 0 00000000 0
N 1100bff8 00000000 0 00000000 0
E 00000000 00000000 0 00000000 0
